//--- Makefile
TOP := cpu_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_cpu
	./obj_dir/sim_cpu +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert #(
	parameter logic [15:0] START_ADR = 16'h0000
) (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire wb_pkg::wb_req_t wb_req_o,
	input wire wb_pkg::wb_rsp_t wb_rsp_i,
	input wire logic halted_o
);

	a_stb_cyc: assert property (@(posedge clk_i) wb_req_o.stb == wb_req_o.cyc)
		else begin
			$error("stb and cyc differ");
			cpu_tb.error_count++;
		end

	a_reset_quiet: assert property (@(posedge clk_i)
		rst_i && $past(rst_i) |-> !wb_req_o.cyc && !wb_req_o.stb
			&& !wb_req_o.we && !halted_o)
		else begin
			$error("bus request or halt seen during reset");
			cpu_tb.error_count++;
		end

	// First access out of reset is the opcode at the reset vector
	a_first_fetch: assert property (@(posedge clk_i)
		$fell(rst_i) |-> wb_req_o.cyc && !wb_req_o.we && wb_req_o.adr == START_ADR)
		else begin
			$error("first request is not an opcode read at the reset vector");
			cpu_tb.error_count++;
		end

	a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_req_o.stb && !wb_rsp_i.ack |=> wb_req_o.stb && $stable(wb_req_o.adr)
			&& $stable(wb_req_o.we) && $stable(wb_req_o.dat))
		else begin
			$error("request changed while waiting for ack");
			cpu_tb.error_count++;
		end

	a_drop: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_req_o.stb && wb_rsp_i.ack |=> !wb_req_o.stb)
		else begin
			$error("stb still high in the cycle after ack");
			cpu_tb.error_count++;
		end

	// Results live in page 3 and the last byte is poison
	a_store_range: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_req_o.stb && wb_req_o.we |-> wb_req_o.adr[15:8] == 8'h03
			&& wb_req_o.adr != 16'h03FF)
		else begin
			$error("write outside the result area");
			cpu_tb.error_count++;
		end

	a_halt_idle: assert property (@(posedge clk_i) halted_o |-> !wb_req_o.cyc)
		else begin
			$error("bus active while halted");
			cpu_tb.error_count++;
		end

	a_halt_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		halted_o |=> halted_o)
		else begin
			$error("core left halt without reset");
			cpu_tb.error_count++;
		end

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	logic clk_i;
	logic rst_i;
	logic halted;
	wb_pkg::wb_req_t wb_req;
	wb_pkg::wb_rsp_t wb_rsp;
	logic [7:0] mem [0:65535];
	integer seed = 32'h4ab6_d30a;
	int error_count;
	int obs_count;
	int n_instr;
	logic [15:0] pp;
	logic [15:0] res_ptr;
	logic [15:0] exp_addr[$];
	logic [7:0] exp_data[$];
	// Reference model state
	logic [7:0] m_a;
	logic [7:0] m_x;
	logic [7:0] m_y;
	logic m_z;
	logic m_c;

	cpu #(.RESET_VECTOR(16'h0200)) dut0 (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_rsp_i(wb_rsp),
		.wb_req_o(wb_req),
		.halted_o(halted)
	);

	bind cpu cpu_assert #(.START_ADR(RESET_VECTOR)) assert0 (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_req_o(wb_req_o),
		.wb_rsp_i(wb_rsp_i),
		.halted_o(halted_o)
	);

	always #2 clk_i = ~clk_i;

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic emit(input logic [7:0] b);
		mem[pp] = b;
		pp = pp + 16'd1;
	endtask

	task automatic set_z(input logic [7:0] v);
		m_z = (v == 8'h00);
	endtask

	task automatic model_op(input logic [7:0] opc, input logic [7:0] v);
		logic [8:0] s;
		case (opc)
			8'hA9, 8'hAD: m_a = v;
			8'hA2, 8'hAE: m_x = v;
			8'hA0, 8'hAC: m_y = v;
			8'h69, 8'h6D, 8'hE9, 8'hED: begin
				// SBC adds the inverted operand and C clear means borrow
				s = {1'b0, m_a} + {1'b0, (opc[7] ? ~v : v)} + {8'h00, m_c};
				m_c = s[8];
				m_a = s[7:0];
			end
			8'h29, 8'h2D: m_a = m_a & v;
			8'h09, 8'h0D: m_a = m_a | v;
			8'h49, 8'h4D: m_a = m_a ^ v;
			8'hE8: m_x = m_x + 8'd1;
			8'hC8: m_y = m_y + 8'd1;
			8'hCA: m_x = m_x - 8'd1;
			8'h88: m_y = m_y - 8'd1;
			8'hAA: m_x = m_a;
			8'h8A: m_a = m_x;
			8'h18: m_c = 1'b0;
			8'h38: m_c = 1'b1;
			default: ;
		endcase
		if (opc inside {8'hA2, 8'hAE, 8'hE8, 8'hCA, 8'hAA})
			set_z(m_x);
		else if (opc inside {8'hA0, 8'hAC, 8'hC8, 8'h88})
			set_z(m_y);
		else if (!(opc inside {8'h18, 8'h38}))
			set_z(m_a);
	endtask

	task automatic imp(input logic [7:0] opc);
		emit(opc);
		model_op(opc, 8'h00);
		n_instr++;
	endtask

	task automatic imm(input logic [7:0] opc, input logic [7:0] v);
		emit(opc);
		emit(v);
		model_op(opc, v);
		n_instr++;
	endtask

	task automatic abs_rd(input logic [7:0] opc, input logic [15:0] adr);
		emit(opc);
		emit(adr[7:0]);
		emit(adr[15:8]);
		model_op(opc, mem[adr]);
		n_instr++;
	endtask

	// STA, STX or STY to the next result byte
	task automatic store(input logic [7:0] opc);
		emit(opc);
		emit(res_ptr[7:0]);
		emit(res_ptr[15:8]);
		exp_addr.push_back(res_ptr);
		exp_data.push_back(opc == 8'h8D ? m_a : (opc == 8'h8E ? m_x : m_y));
		res_ptr = res_ptr + 16'd1;
		n_instr++;
	endtask

	// Not-taken path stores nt and jumps over the taken path, which stores t
	task automatic branch(input logic [7:0] opc, input logic [7:0] t, input logic [7:0] nt);
		logic taken;
		logic [15:0] done_adr;
		taken = (opc == 8'hF0) ? m_z : !m_z;
		emit(opc);
		emit(8'd8);
		done_adr = pp + 16'd13;
		emit(8'hA9);
		emit(nt);
		emit(8'h8D);
		emit(res_ptr[7:0]);
		emit(res_ptr[15:8]);
		emit(8'h4C);
		emit(done_adr[7:0]);
		emit(done_adr[15:8]);
		emit(8'hA9);
		emit(t);
		emit(8'h8D);
		emit(res_ptr[7:0] + 8'd1);
		emit(res_ptr[15:8]);
		m_a = taken ? t : nt;
		set_z(m_a);
		exp_addr.push_back(taken ? res_ptr + 16'd1 : res_ptr);
		exp_data.push_back(m_a);
		res_ptr = res_ptr + 16'd2;
		n_instr += 5;
	endtask

	task automatic build_program();
		logic [7:0] r;
		logic [15:0] skip;
		for (int i = 0; i < 65536; i++)
			mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
		for (int i = 0; i < 16; i++)
			mem[16'h0400 + i[15:0]] = rand_byte();
		pp = 16'h0200;
		res_ptr = 16'h0300;
		imm(8'hA9, rand_byte());
		store(8'h8D);
		imm(8'hA2, rand_byte());
		store(8'h8E);
		imm(8'hA0, rand_byte());
		store(8'h8C);
		imp(8'h18);
		imm(8'h69, rand_byte());
		store(8'h8D);
		imp(8'h38);
		imm(8'h69, rand_byte());
		store(8'h8D);
		imp(8'h38);
		imm(8'hE9, rand_byte());
		store(8'h8D);
		imp(8'h18);
		imm(8'hE9, rand_byte());
		store(8'h8D);
		imm(8'h29, rand_byte());
		store(8'h8D);
		imm(8'h09, rand_byte());
		store(8'h8D);
		imm(8'h49, rand_byte());
		store(8'h8D);
		abs_rd(8'hAD, 16'h0400);
		store(8'h8D);
		abs_rd(8'h6D, 16'h0401);
		store(8'h8D);
		abs_rd(8'hED, 16'h0402);
		store(8'h8D);
		abs_rd(8'h2D, 16'h0403);
		store(8'h8D);
		abs_rd(8'h0D, 16'h0404);
		store(8'h8D);
		abs_rd(8'h4D, 16'h0405);
		store(8'h8D);
		abs_rd(8'hAE, 16'h0406);
		store(8'h8E);
		abs_rd(8'hAC, 16'h0407);
		store(8'h8C);
		imp(8'hE8);
		store(8'h8E);
		imp(8'hC8);
		store(8'h8C);
		imp(8'hCA);
		store(8'h8E);
		imp(8'h88);
		store(8'h8C);
		imp(8'hAA);
		store(8'h8E);
		imm(8'hA2, rand_byte());
		imp(8'h8A);
		store(8'h8D);
		imm(8'hA9, 8'h00);
		branch(8'hF0, 8'h11, 8'h12);
		imm(8'hA9, 8'h00);
		branch(8'hD0, 8'h21, 8'h22);
		imm(8'hA9, rand_byte() | 8'h01);
		branch(8'hF0, 8'h31, 8'h32);
		imm(8'hA9, rand_byte() | 8'h01);
		branch(8'hD0, 8'h41, 8'h42);
		// Equal operands give zero with no borrow
		r = rand_byte();
		imm(8'hA9, r);
		imp(8'h38);
		imm(8'hE9, r);
		branch(8'hF0, 8'h51, 8'h52);
		imm(8'hA9, 8'h00);
		imm(8'h69, 8'h00);
		store(8'h8D);
		skip = pp + 16'd8;
		emit(8'h4C);
		emit(skip[7:0]);
		emit(skip[15:8]);
		emit(8'hA9);
		emit(8'hEE);
		emit(8'h8D);
		emit(8'hFF);
		emit(8'h03);
		n_instr += 3;
		imp(8'h00);
	endtask

	task automatic check_store(input logic [15:0] adr, input logic [7:0] dat);
		if (obs_count >= exp_addr.size()) begin
			$display("Unexpected store of %02h to %04h at %0t", dat, adr, $time);
			error_count++;
		end else if (adr != exp_addr[obs_count]) begin
			$display("Store went to %04h instead of %04h at %0t", adr,
				exp_addr[obs_count], $time);
			error_count++;
		end else if (dat != exp_data[obs_count]) begin
			$display("MISMATCH time=%0t wb_req_o.dat expected=%02h actual=%02h",
				$time, exp_data[obs_count], dat);
			error_count++;
		end
		obs_count++;
	endtask

	// Memory with 0 to 3 wait states per access
	initial begin
		logic pending;
		logic in_reset;
		int waits;
		pending = 1'b0;
		waits = 0;
		forever begin
			@(posedge clk_i);
			in_reset = rst_i;
			#1;
			if (in_reset || wb_rsp.ack) begin
				wb_rsp.ack = 1'b0;
				pending = 1'b0;
			end else if (wb_req.cyc && wb_req.stb) begin
				if (!pending) begin
					pending = 1'b1;
					waits = $random(seed) & 32'h3;
				end
				if (waits == 0) begin
					wb_rsp.ack = 1'b1;
					if (wb_req.we) begin
						mem[wb_req.adr] = wb_req.dat;
						check_store(wb_req.adr, wb_req.dat);
					end else begin
						wb_rsp.dat = mem[wb_req.adr];
					end
				end else begin
					waits--;
				end
			end
		end
	end

	initial begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		wb_rsp = '0;
		error_count = 0;
		obs_count = 0;
		n_instr = 0;
		{m_a, m_x, m_y} = '0;
		{m_z, m_c} = '0;
		build_program();
		repeat (8) @(posedge clk_i);
		#1 rst_i = 1'b0;
		wait (halted === 1'b1);
		repeat (5) @(posedge clk_i);
		if (obs_count != exp_addr.size()) begin
			$display("Store count is %0d but %0d were expected", obs_count,
				exp_addr.size());
			error_count++;
		end
		$display("errors=%0d expected_stores=%0d observed_stores=%0d",
			error_count, exp_addr.size(), obs_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Worst case is four accesses of five cycles per instruction
	initial begin
		wait (rst_i === 1'b0);
		repeat (n_instr * 4 * 5 + 100) @(posedge clk_i);
		$display("Timeout, the core did not halt within %0d cycles", n_instr * 20 + 100);
		error_count++;
		$display("errors=%0d expected_stores=%0d observed_stores=%0d",
			error_count, exp_addr.size(), obs_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire logic [7:0] a_i,
	input wire logic [7:0] b_i,
	input wire cpu_pkg::alu_func_t func_i,
	input wire logic carry_i,
	output cpu_pkg::alu_result_t res_o
);

	logic [7:0] b_eff;
	logic [8:0] sum;

	// Subtract adds the complement, C set means no borrow
	always_comb begin
		b_eff = (func_i == cpu_pkg::alu_sub) ? ~b_i : b_i;
		sum = {1'b0, a_i} + {1'b0, b_eff} + {8'h00, carry_i};
	end

	always_comb begin
		res_o.flags.c = carry_i;
		res_o.flags.v = 1'b0;
		case (func_i)
			cpu_pkg::alu_add, cpu_pkg::alu_sub: begin
				res_o.value = sum[7:0];
				res_o.flags.c = sum[8];
				// Overflow when both inputs share a sign the result lacks
				res_o.flags.v = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);
			end
			cpu_pkg::alu_and:
				res_o.value = a_i & b_i;
			cpu_pkg::alu_or:
				res_o.value = a_i | b_i;
			cpu_pkg::alu_xor:
				res_o.value = a_i ^ b_i;
			cpu_pkg::alu_inc:
				res_o.value = a_i + 8'd1;
			cpu_pkg::alu_dec:
				res_o.value = a_i - 8'd1;
			// Pass forwards operand b
			default:
				res_o.value = b_i;
		endcase
		res_o.flags.n = res_o.value[7];
		res_o.flags.z = (res_o.value == 8'h00);
	end

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire wb_pkg::wb_rsp_t wb_rsp_i,
	output wb_pkg::wb_req_t wb_req_o,
	output logic halted_o
);

	cpu_pkg::decode_t dec;
	cpu_pkg::alu_result_t res;
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::reg_sel_t dest;
	cpu_pkg::alu_func_t alu_func;
	cpu_pkg::flags_t flags;
	logic [7:0] opcode;
	logic [7:0] a;
	logic [7:0] x;
	logic [7:0] y;
	logic [7:0] alu_a;
	logic [7:0] alu_b;
	logic [7:0] offset;
	logic [15:0] pc_val;
	logic [15:0] target;

	sequencer seq0 (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dec_i(dec),
		.a_i(a),
		.x_i(x),
		.y_i(y),
		.flags_i(flags),
		.res_i(res),
		.pc_i(pc_val),
		.wb_rsp_i(wb_rsp_i),
		.wb_req_o(wb_req_o),
		.opcode_o(opcode),
		.alu_a_o(alu_a),
		.alu_b_o(alu_b),
		.alu_func_o(alu_func),
		.ctrl_o(ctrl),
		.dest_o(dest),
		.target_o(target),
		.offset_o(offset),
		.halted_o(halted_o)
	);

	idec idec0 (
		.opcode_i(opcode),
		.dec_o(dec)
	);

	// Carry in is the live C flag for every function
	alu alu0 (
		.a_i(alu_a),
		.b_i(alu_b),
		.func_i(alu_func),
		.carry_i(flags.c),
		.res_o(res)
	);

	reg_bank regs0 (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ctrl_i(ctrl),
		.dest_i(dest),
		.res_i(res),
		.a_o(a),
		.x_o(x),
		.y_o(y),
		.flags_o(flags)
	);

	pc #(
		.RESET_VECTOR(RESET_VECTOR)
	) pc0 (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ctrl_i(ctrl),
		.target_i(target),
		.offset_i(offset),
		.pc_o(pc_val)
	);

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Operations of the supported subset, anything else runs as op_nop
	typedef enum logic [4:0] {
		op_nop, op_lda, op_ldx, op_ldy, op_sta, op_stx, op_sty,
		op_adc, op_sbc, op_and, op_ora, op_eor,
		op_inx, op_iny, op_dex, op_dey, op_tax, op_txa,
		op_clc, op_sec, op_jmp, op_beq, op_bne, op_brk
	} opcode_t;

	typedef enum logic [1:0] {am_imp, am_imm, am_abs, am_rel} addr_mode_t;

	typedef enum logic [2:0] {
		alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_inc, alu_dec
	} alu_func_t;

	typedef enum logic [1:0] {reg_a, reg_x, reg_y, reg_none} reg_sel_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		logic [7:0] value;
		flags_t flags;
	} alu_result_t;

	typedef struct packed {
		opcode_t op;
		addr_mode_t mode;
		alu_func_t func;
		reg_sel_t dest;
		reg_sel_t src;
		logic store;
		logic mem_rd;
		logic flag_upd;
	} decode_t;

	// Sequencer strobes to register bank and program counter
	typedef struct packed {
		logic reg_we;
		logic flags_we;
		logic set_c;
		logic clr_c;
		logic pc_inc;
		logic pc_load;
		logic pc_branch;
	} ctrl_t;

endpackage

`default_nettype wire

//--- design/idec.sv
`timescale 1ns/1ps
`default_nettype none

module idec (
	input wire logic [7:0] opcode_i,
	output cpu_pkg::decode_t dec_o
);

	always_comb begin
		dec_o = '0;
		dec_o.op = cpu_pkg::op_nop;
		dec_o.mode = cpu_pkg::am_imp;
		dec_o.func = cpu_pkg::alu_pass;
		dec_o.dest = cpu_pkg::reg_none;
		dec_o.src = cpu_pkg::reg_none;

		case (opcode_i)
			8'hA9, 8'hAD: dec_o.op = cpu_pkg::op_lda;
			8'hA2, 8'hAE: dec_o.op = cpu_pkg::op_ldx;
			8'hA0, 8'hAC: dec_o.op = cpu_pkg::op_ldy;
			8'h8D: dec_o.op = cpu_pkg::op_sta;
			8'h8E: dec_o.op = cpu_pkg::op_stx;
			8'h8C: dec_o.op = cpu_pkg::op_sty;
			8'h69, 8'h6D: dec_o.op = cpu_pkg::op_adc;
			8'hE9, 8'hED: dec_o.op = cpu_pkg::op_sbc;
			8'h29, 8'h2D: dec_o.op = cpu_pkg::op_and;
			8'h09, 8'h0D: dec_o.op = cpu_pkg::op_ora;
			8'h49, 8'h4D: dec_o.op = cpu_pkg::op_eor;
			8'hE8: dec_o.op = cpu_pkg::op_inx;
			8'hC8: dec_o.op = cpu_pkg::op_iny;
			8'hCA: dec_o.op = cpu_pkg::op_dex;
			8'h88: dec_o.op = cpu_pkg::op_dey;
			8'hAA: dec_o.op = cpu_pkg::op_tax;
			8'h8A: dec_o.op = cpu_pkg::op_txa;
			8'h18: dec_o.op = cpu_pkg::op_clc;
			8'h38: dec_o.op = cpu_pkg::op_sec;
			8'h4C: dec_o.op = cpu_pkg::op_jmp;
			8'hF0: dec_o.op = cpu_pkg::op_beq;
			8'hD0: dec_o.op = cpu_pkg::op_bne;
			8'h00: dec_o.op = cpu_pkg::op_brk;
			default: ;
		endcase

		case (opcode_i)
			8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49:
				dec_o.mode = cpu_pkg::am_imm;
			8'hAD, 8'hAE, 8'hAC, 8'h8D, 8'h8E, 8'h8C,
			8'h6D, 8'hED, 8'h2D, 8'h0D, 8'h4D, 8'h4C:
				dec_o.mode = cpu_pkg::am_abs;
			8'hF0, 8'hD0:
				dec_o.mode = cpu_pkg::am_rel;
			default: ;
		endcase

		case (dec_o.op)
			cpu_pkg::op_adc: dec_o.func = cpu_pkg::alu_add;
			cpu_pkg::op_sbc: dec_o.func = cpu_pkg::alu_sub;
			cpu_pkg::op_and: dec_o.func = cpu_pkg::alu_and;
			cpu_pkg::op_ora: dec_o.func = cpu_pkg::alu_or;
			cpu_pkg::op_eor: dec_o.func = cpu_pkg::alu_xor;
			cpu_pkg::op_inx, cpu_pkg::op_iny: dec_o.func = cpu_pkg::alu_inc;
			cpu_pkg::op_dex, cpu_pkg::op_dey: dec_o.func = cpu_pkg::alu_dec;
			default: ;
		endcase

		case (dec_o.op)
			cpu_pkg::op_lda, cpu_pkg::op_adc, cpu_pkg::op_sbc, cpu_pkg::op_and,
			cpu_pkg::op_ora, cpu_pkg::op_eor, cpu_pkg::op_txa:
				dec_o.dest = cpu_pkg::reg_a;
			cpu_pkg::op_ldx, cpu_pkg::op_inx, cpu_pkg::op_dex, cpu_pkg::op_tax:
				dec_o.dest = cpu_pkg::reg_x;
			cpu_pkg::op_ldy, cpu_pkg::op_iny, cpu_pkg::op_dey:
				dec_o.dest = cpu_pkg::reg_y;
			default: ;
		endcase

		// Source feeds ALU operand a and, for stores, the write data
		case (dec_o.op)
			cpu_pkg::op_sta, cpu_pkg::op_adc, cpu_pkg::op_sbc, cpu_pkg::op_and,
			cpu_pkg::op_ora, cpu_pkg::op_eor, cpu_pkg::op_tax:
				dec_o.src = cpu_pkg::reg_a;
			cpu_pkg::op_stx, cpu_pkg::op_inx, cpu_pkg::op_dex, cpu_pkg::op_txa:
				dec_o.src = cpu_pkg::reg_x;
			cpu_pkg::op_sty, cpu_pkg::op_iny, cpu_pkg::op_dey:
				dec_o.src = cpu_pkg::reg_y;
			default: ;
		endcase

		dec_o.store = dec_o.op inside {cpu_pkg::op_sta, cpu_pkg::op_stx, cpu_pkg::op_sty};
		dec_o.mem_rd = (dec_o.mode == cpu_pkg::am_abs) && !dec_o.store
			&& (dec_o.op != cpu_pkg::op_jmp);
		// Every register write sets N and Z
		dec_o.flag_upd = (dec_o.dest != cpu_pkg::reg_none);
	end

endmodule

`default_nettype wire

//--- design/pc.sv
`timescale 1ns/1ps
`default_nettype none

module pc #(
	parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire cpu_pkg::ctrl_t ctrl_i,
	input wire logic [15:0] target_i,
	input wire logic [7:0] offset_i,
	output logic [15:0] pc_o
);

	logic [15:0] offset_ext;

	assign offset_ext = {{8{offset_i[7]}}, offset_i};

	// Load and branch win over increment
	always_ff @(posedge clk_i) begin
		if (rst_i)
			pc_o <= RESET_VECTOR;
		else if (ctrl_i.pc_load)
			pc_o <= target_i;
		else if (ctrl_i.pc_branch)
			pc_o <= pc_o + offset_ext;
		else if (ctrl_i.pc_inc)
			pc_o <= pc_o + 16'd1;
	end

endmodule

`default_nettype wire

//--- design/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire cpu_pkg::ctrl_t ctrl_i,
	input wire cpu_pkg::reg_sel_t dest_i,
	input wire cpu_pkg::alu_result_t res_i,
	output logic [7:0] a_o,
	output logic [7:0] x_o,
	output logic [7:0] y_o,
	output cpu_pkg::flags_t flags_o
);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			a_o <= 8'h00;
			x_o <= 8'h00;
			y_o <= 8'h00;
		end else if (ctrl_i.reg_we) begin
			case (dest_i)
				cpu_pkg::reg_a: a_o <= res_i.value;
				cpu_pkg::reg_x: x_o <= res_i.value;
				cpu_pkg::reg_y: y_o <= res_i.value;
				default: ;
			endcase
		end
	end

	// C from logic and increment results is the old carry handed back by the ALU
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			flags_o <= '0;
		end else begin
			if (ctrl_i.flags_we) begin
				flags_o.n <= res_i.flags.n;
				flags_o.z <= res_i.flags.z;
				flags_o.v <= res_i.flags.v;
				flags_o.c <= res_i.flags.c;
			end
			// CLC and SEC
			if (ctrl_i.set_c)
				flags_o.c <= 1'b1;
			else if (ctrl_i.clr_c)
				flags_o.c <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire cpu_pkg::decode_t dec_i,
	input wire logic [7:0] a_i,
	input wire logic [7:0] x_i,
	input wire logic [7:0] y_i,
	input wire cpu_pkg::flags_t flags_i,
	input wire cpu_pkg::alu_result_t res_i,
	input wire logic [15:0] pc_i,
	input wire wb_pkg::wb_rsp_t wb_rsp_i,
	output wb_pkg::wb_req_t wb_req_o,
	output logic [7:0] opcode_o,
	output logic [7:0] alu_a_o,
	output logic [7:0] alu_b_o,
	output cpu_pkg::alu_func_t alu_func_o,
	output cpu_pkg::ctrl_t ctrl_o,
	output cpu_pkg::reg_sel_t dest_o,
	output logic [15:0] target_o,
	output logic [7:0] offset_o,
	output logic halted_o
);

	typedef enum logic [2:0] {
		FETCH_OP, FETCH_LO, FETCH_HI, MEM_READ, MEM_WRITE, EXECUTE, HALT
	} state_t;

	state_t state;
	state_t state_d;
	logic done;
	logic fetch;
	logic req_active;
	logic ack;
	logic [7:0] opcode_q;
	logic [7:0] lo_q;
	logic [7:0] hi_q;
	logic [7:0] src_val;

	assign fetch = (state == FETCH_OP) || (state == FETCH_LO) || (state == FETCH_HI);
	// Bus stays idle while reset is held
	assign req_active = !rst_i && !done
		&& (fetch || state == MEM_READ || state == MEM_WRITE);
	assign ack = req_active && wb_rsp_i.ack;
	assign halted_o = (state == HALT);

	// done marks the idle cycle after each ack
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= FETCH_OP;
			done <= 1'b0;
		end else begin
			state <= state_d;
			done <= ack;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ack) begin
			case (state)
				FETCH_OP: opcode_q <= wb_rsp_i.dat;
				FETCH_HI: hi_q <= wb_rsp_i.dat;
				// Read data replaces the low operand byte
				FETCH_LO, MEM_READ: lo_q <= wb_rsp_i.dat;
				default: ;
			endcase
		end
	end

	always_comb begin
		state_d = state;
		case (state)
			FETCH_OP: begin
				if (done) begin
					if (dec_i.op == cpu_pkg::op_brk)
						state_d = HALT;
					else if (dec_i.mode == cpu_pkg::am_imp)
						state_d = EXECUTE;
					else
						state_d = FETCH_LO;
				end
			end
			FETCH_LO: begin
				if (done) begin
					if (dec_i.mode == cpu_pkg::am_abs)
						state_d = FETCH_HI;
					else
						state_d = EXECUTE;
				end
			end
			FETCH_HI: begin
				if (done) begin
					if (dec_i.store)
						state_d = MEM_WRITE;
					else if (dec_i.mem_rd)
						state_d = MEM_READ;
					else
						state_d = EXECUTE;
				end
			end
			MEM_READ: if (done) state_d = EXECUTE;
			MEM_WRITE: if (done) state_d = FETCH_OP;
			EXECUTE: state_d = FETCH_OP;
			default: ;
		endcase
	end

	always_comb begin
		case (dec_i.src)
			cpu_pkg::reg_a: src_val = a_i;
			cpu_pkg::reg_x: src_val = x_i;
			cpu_pkg::reg_y: src_val = y_i;
			default: src_val = 8'h00;
		endcase
	end

	// Memory operands come through the low latch
	assign alu_a_o = src_val;
	assign alu_b_o = (dec_i.mode == cpu_pkg::am_imm || dec_i.mem_rd) ? lo_q : src_val;
	assign alu_func_o = dec_i.func;
	assign dest_o = dec_i.dest;
	assign opcode_o = opcode_q;
	assign target_o = {hi_q, lo_q};
	assign offset_o = lo_q;

	always_comb begin
		wb_req_o = '0;
		wb_req_o.cyc = req_active;
		wb_req_o.stb = req_active;
		wb_req_o.we = req_active && (state == MEM_WRITE);
		wb_req_o.adr = fetch ? pc_i : {hi_q, lo_q};
		// Stores pass the source register through the ALU
		if (state == MEM_WRITE)
			wb_req_o.dat = res_i.value;
	end

	always_comb begin
		ctrl_o = '0;
		ctrl_o.pc_inc = ack && fetch;
		if (state == EXECUTE) begin
			ctrl_o.reg_we = (dec_i.dest != cpu_pkg::reg_none);
			ctrl_o.flags_we = dec_i.flag_upd;
			ctrl_o.set_c = (dec_i.op == cpu_pkg::op_sec);
			ctrl_o.clr_c = (dec_i.op == cpu_pkg::op_clc);
			ctrl_o.pc_load = (dec_i.op == cpu_pkg::op_jmp);
			ctrl_o.pc_branch = (dec_i.op == cpu_pkg::op_beq && flags_i.z)
				|| (dec_i.op == cpu_pkg::op_bne && !flags_i.z);
		end
	end

endmodule

`default_nettype wire

//--- design/wb_pkg.sv
`default_nettype none

package wb_pkg;

	localparam int WB_ADDR_W = 16;
	localparam int WB_DATA_W = 8;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- sources.f
design/cpu_pkg.sv
design/wb_pkg.sv
design/alu.sv
design/reg_bank.sv
design/pc.sv
design/idec.sv
design/sequencer.sv
design/cpu.sv
bench/cpu_assert.sv
bench/cpu_tb.sv
